/* verilog/soc_io_pkg.sv */
////////////////////////////////////////
// Bus types, select codes and I/O map shared by
// the decoder and the register-mapped peripherals.
// Modules import it inside their bodies.
////////////////////////////////////////
`default_nettype none

package soc_io_pkg;

    // Host I/O request, word addressed
    typedef struct packed {
        logic        access;
        logic        wr_en;
        logic [1:0]  bytesel;
        logic [15:1] addr;
        logic [15:0] wdata;
        logic        reserved;
    } io_req_t;

    // Per-block response, rdata is zero outside ack
    typedef struct packed {
        logic        ack;
        logic [15:0] rdata;
    } io_rsp_t;

    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_SYSCTL,
        SEL_TIMER,
        SEL_IRQ,
        SEL_DEFAULT
    } io_sel_e;

    typedef enum logic [1:0] {
        TIMER_STOPPED,
        TIMER_ONESHOT,
        TIMER_PERIODIC
    } timer_mode_e;

    // I/O address map (byte addresses)
    localparam logic [15:0] ADDR_LEDS        = 16'hfffe;
    localparam logic [15:0] ADDR_BIOS_CTRL   = 16'hffec;
    localparam logic [15:0] ADDR_IRQ_TEST    = 16'hfff6;
    localparam logic [15:0] ADDR_TIMER_COUNT = 16'h0040;
    localparam logic [15:0] ADDR_TIMER_CTRL  = 16'h0042;
    localparam logic [15:0] ADDR_PIC         = 16'h0020;

    localparam int IRQ_TIMER = 0; // Timer owns line 0

endpackage

`default_nettype wire

/* verilog/io_decoder.sv */
////////////////////////////////////////
// I/O address decode and response fabric.
// One select strobe per access, a default ack for
// unmapped addresses, responses merged by OR.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module io_decoder (
    input  wire logic                 sys_clk,
    input  wire logic                 rst_n,
    input  wire soc_io_pkg::io_req_t  io_req,
    input  wire soc_io_pkg::io_rsp_t  sysctl_rsp,
    input  wire soc_io_pkg::io_rsp_t  timer_rsp,
    input  wire soc_io_pkg::io_rsp_t  irq_rsp,
    output logic                      sysctl_sel,
    output logic                      timer_sel,
    output logic                      irq_sel,
    output soc_io_pkg::io_rsp_t       io_rsp
);
    import soc_io_pkg::*;

    io_sel_e io_sel;
    logic    seen_q;     // access was high last cycle
    logic    new_access;
    logic    dflt_sel_q;
    logic    dflt_ack_q;

    assign new_access = io_req.access && !seen_q; // Only the first cycle of an access

    always_comb begin
        io_sel = SEL_NONE;
        if (new_access) begin
            unique case ({io_req.addr, 1'b0})
                ADDR_LEDS, ADDR_BIOS_CTRL:         io_sel = SEL_SYSCTL;
                ADDR_TIMER_COUNT, ADDR_TIMER_CTRL: io_sel = SEL_TIMER;
                ADDR_PIC, ADDR_IRQ_TEST:           io_sel = SEL_IRQ;
                default:                           io_sel = SEL_DEFAULT;
            endcase
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_q     <= 1'b0;
            sysctl_sel <= 1'b0;
            timer_sel  <= 1'b0;
            irq_sel    <= 1'b0;
            dflt_sel_q <= 1'b0;
            dflt_ack_q <= 1'b0;
        end else begin
            seen_q     <= io_req.access;
            sysctl_sel <= (io_sel == SEL_SYSCTL);
            timer_sel  <= (io_sel == SEL_TIMER);
            irq_sel    <= (io_sel == SEL_IRQ);
            dflt_sel_q <= (io_sel == SEL_DEFAULT);
            dflt_ack_q <= dflt_sel_q; // Same latency as a real peripheral
        end
    end

    // Default responder contributes ack only, its data is always zero
    always_comb begin
        io_rsp.ack   = sysctl_rsp.ack | timer_rsp.ack | irq_rsp.ack | dflt_ack_q;
        io_rsp.rdata = sysctl_rsp.rdata | timer_rsp.rdata | irq_rsp.rdata;
    end

    // OR merge needs a single responder per cycle
    a_one_ack: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $onehot0({sysctl_rsp.ack, timer_rsp.ack, irq_rsp.ack, dflt_ack_q}));

endmodule

`default_nettype wire

/* verilog/system_control.sv */
////////////////////////////////////////
// System control registers: LED output register
// and the BIOS-enable flag, byte-lane writable.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module system_control #(
    parameter int num_leds = 8
) (
    input  wire logic                 sys_clk,
    input  wire logic                 rst_n,
    input  wire logic                 sel,
    input  wire soc_io_pkg::io_req_t  io_req,
    output soc_io_pkg::io_rsp_t       rsp,
    output logic [num_leds-1:0]       leds,
    output logic                      bios_enabled
);
    import soc_io_pkg::*;

    logic        is_leds;
    logic        wr;
    logic [15:0] rd_val;

    assign is_leds = ({io_req.addr, 1'b0} == ADDR_LEDS); // Else BIOS control
    assign wr      = sel && io_req.wr_en;
    assign rd_val  = is_leds ? 16'(leds) : {15'b0, bios_enabled};

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            leds         <= '0;
            bios_enabled <= 1'b1; // Boot from ROM
        end else if (wr) begin
            if (is_leds) begin
                for (int i = 0; i < num_leds; i++) begin
                    if (io_req.bytesel[i / 8])
                        leds[i] <= io_req.wdata[i];
                end
            end else if (io_req.bytesel[0]) begin
                bios_enabled <= io_req.wdata[0];
            end
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp <= '0;
        end else begin
            rsp.ack   <= sel;
            rsp.rdata <= (sel && !io_req.wr_en) ? rd_val : 16'h0;
        end
    end

    // Single ack pulse per strobe, relies on the decoder firing once
    a_ack_pulse: assert property (@(posedge sys_clk) disable iff (!rst_n)
        sel |=> rsp.ack ##1 !rsp.ack);

endmodule

`default_nettype wire

/* verilog/interval_timer.sv */
////////////////////////////////////////
// Programmable interval timer. A prescaled 16-bit
// down-counter, one-shot or periodic, that pulses
// timer_irq each time it reaches zero.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module interval_timer #(
    parameter int timer_prescale = 4
) (
    input  wire logic                 sys_clk,
    input  wire logic                 rst_n,
    input  wire logic                 sel,
    input  wire soc_io_pkg::io_req_t  io_req,
    output soc_io_pkg::io_rsp_t       rsp,
    output logic                      timer_irq
);
    import soc_io_pkg::*;

    localparam int pre_w = (timer_prescale > 1) ? $clog2(timer_prescale) : 1;

    timer_mode_e      mode_q;
    logic [15:0]      reload_q;
    logic [15:0]      count_q;
    logic [pre_w-1:0] pre_cnt;
    logic             tick;
    logic             running;
    logic             is_ctrl;
    logic             wr;
    logic [15:0]      wr_count;
    logic [15:0]      rd_val;

    assign is_ctrl = ({io_req.addr, 1'b0} == ADDR_TIMER_CTRL);
    assign wr      = sel && io_req.wr_en;
    assign running = (mode_q != TIMER_STOPPED);
    assign tick    = running && (pre_cnt == pre_w'(timer_prescale - 1));

    // Merge enabled lanes over the old reload value
    assign wr_count = {io_req.bytesel[1] ? io_req.wdata[15:8] : reload_q[15:8],
                       io_req.bytesel[0] ? io_req.wdata[7:0]  : reload_q[7:0]};

    assign rd_val = is_ctrl ? {14'b0, mode_q} : count_q;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q    <= TIMER_STOPPED;
            reload_q  <= '0;
            count_q   <= '0;
            pre_cnt   <= '0;
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= 1'b0;
            if (wr && !is_ctrl) begin
                reload_q <= wr_count;
                count_q  <= wr_count;
                pre_cnt  <= '0; // Restart the period from this write
            end else if (wr && is_ctrl) begin
                if (io_req.bytesel[0]) begin
                    if (io_req.wdata[1:0] == 2'b11)
                        mode_q <= TIMER_STOPPED;
                    else
                        mode_q <= timer_mode_e'(io_req.wdata[1:0]);
                    pre_cnt <= '0;
                end
            end else if (running) begin
                pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
                if (tick) begin
                    if (count_q <= 16'd1) begin
                        timer_irq <= 1'b1;
                        if (mode_q == TIMER_PERIODIC) begin
                            count_q <= reload_q;
                        end else begin
                            count_q <= '0;
                            mode_q  <= TIMER_STOPPED;
                        end
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp <= '0;
        end else begin
            rsp.ack   <= sel;
            rsp.rdata <= (sel && !io_req.wr_en) ? rd_val : 16'h0;
        end
    end

endmodule

`default_nettype wire

/* verilog/irq_controller.sv */
////////////////////////////////////////
// Interrupt controller. Latches rising edges of 8
// lines, masks them and reports the lowest pending
// line. Also holds the test-interrupt register.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module irq_controller (
    input  wire logic                 sys_clk,
    input  wire logic                 rst_n,
    input  wire logic                 sel,
    input  wire soc_io_pkg::io_req_t  io_req,
    output soc_io_pkg::io_rsp_t       rsp,
    input  wire logic                 timer_irq,
    input  wire logic [6:0]           irq_in,
    output logic                      intr,
    output logic [2:0]                irq_num
);
    import soc_io_pkg::*;

    logic [6:0]  test_q;
    logic [7:0]  mask_q;   // 1 masks the line
    logic [7:0]  pending_q;
    logic [7:0]  lines;
    logic [7:0]  lines_q;
    logic [7:0]  rise;
    logic [7:0]  eoi;
    logic [7:0]  active;
    logic        is_pic;
    logic        wr;
    logic [15:0] rd_val;

    always_comb begin
        lines            = {irq_in | test_q, 1'b0};
        lines[IRQ_TIMER] = timer_irq;
    end

    assign rise   = lines & ~lines_q;
    assign is_pic = ({io_req.addr, 1'b0} == ADDR_PIC); // Else test register
    assign wr     = sel && io_req.wr_en;
    assign eoi    = (wr && is_pic && io_req.bytesel[0]) ? io_req.wdata[7:0] : 8'h0;
    assign rd_val = is_pic ? {mask_q, pending_q} : {9'b0, test_q};

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            lines_q   <= '0;
            pending_q <= '0;
            mask_q    <= '0;
            test_q    <= '0;
        end else begin
            lines_q   <= lines;
            pending_q <= (pending_q & ~eoi) | rise; // New edge beats EOI
            if (wr && is_pic && io_req.bytesel[1])
                mask_q <= io_req.wdata[15:8];
            if (wr && !is_pic && io_req.bytesel[0])
                test_q <= io_req.wdata[6:0];
        end
    end

    // Lowest-numbered unmasked pending line wins
    assign active = pending_q & ~mask_q;
    assign intr   = |active;

    always_comb begin
        irq_num = 3'd0;
        for (int i = 7; i >= 0; i--) begin
            if (active[i])
                irq_num = 3'(i);
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp <= '0;
        end else begin
            rsp.ack   <= sel;
            rsp.rdata <= (sel && !io_req.wr_en) ? rd_val : 16'h0;
        end
    end

    a_intr_valid: assert property (@(posedge sys_clk) disable iff (!rst_n)
        intr |-> (pending_q[irq_num] && !mask_q[irq_num]));

endmodule

`default_nettype wire

/* verilog/io_subsystem_top.sv */
////////////////////////////////////////
// I/O subsystem top level. Wires the host bus to
// the decoder, the three peripherals and the
// interrupt sources. Access latency is 2 cycles.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module io_subsystem_top #(
    parameter int num_leds       = 8,
    parameter int timer_prescale = 4
) (
    input  wire logic                 sys_clk,
    input  wire logic                 rst_n,
    input  wire soc_io_pkg::io_req_t  io_req,
    output soc_io_pkg::io_rsp_t       io_rsp,
    input  wire logic [6:0]           irq_in,
    output logic [num_leds-1:0]       leds,
    output logic                      bios_enabled,
    output logic                      intr,
    output logic [2:0]                irq_num
);
    import soc_io_pkg::*;

    logic    sysctl_sel;
    logic    timer_sel;
    logic    irq_sel;
    io_rsp_t sysctl_rsp;
    io_rsp_t timer_rsp;
    io_rsp_t irq_rsp;
    logic    timer_irq;

    io_decoder u_io_decoder (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .io_req     (io_req),
        .sysctl_rsp (sysctl_rsp),
        .timer_rsp  (timer_rsp),
        .irq_rsp    (irq_rsp),
        .sysctl_sel (sysctl_sel),
        .timer_sel  (timer_sel),
        .irq_sel    (irq_sel),
        .io_rsp     (io_rsp)
    );

    system_control #(.num_leds(num_leds)) u_system_control (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .sel          (sysctl_sel),
        .io_req       (io_req),
        .rsp          (sysctl_rsp),
        .leds         (leds),
        .bios_enabled (bios_enabled)
    );

    interval_timer #(.timer_prescale(timer_prescale)) u_interval_timer (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .sel       (timer_sel),
        .io_req    (io_req),
        .rsp       (timer_rsp),
        .timer_irq (timer_irq)
    );

    irq_controller u_irq_controller (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .sel       (irq_sel),
        .io_req    (io_req),
        .rsp       (irq_rsp),
        .timer_irq (timer_irq), // Line 0
        .irq_in    (irq_in),    // Lines 1 to 7
        .intr      (intr),
        .irq_num   (irq_num)
    );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
////////////////////////////////////////
// Testbench clock and reset source.
// Free-running sys_clk, rst_n held low at start.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int period       = 100,
    parameter int reset_cycles = 4
) (
    output logic sys_clk,
    output logic rst_n
);
    initial begin
        sys_clk = 1'b0;
        forever #(period / 2) sys_clk = ~sys_clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge sys_clk);
        @(negedge sys_clk);
        rst_n = 1'b1; // Release away from the active edge
    end

endmodule

`default_nettype wire

/* verification/io_subsystem_tb.sv */
////////////////////////////////////////
// Testbench for the I/O subsystem. Host accesses
// are driven on the falling edge, concurrent
// assertions check every response.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module io_subsystem_tb;
    import soc_io_pkg::*;

    localparam int num_leds        = 8;
    localparam int timer_prescale  = 4;
    localparam int watchdog_cycles = 20000; // Tests need well under a thousand cycles

    logic                sys_clk;
    logic                rst_n;
    io_req_t             io_req;
    io_rsp_t             io_rsp;
    logic [6:0]          irq_in;
    logic [num_leds-1:0] leds;
    logic                bios_enabled;
    logic                intr;
    logic [2:0]          irq_num;

    int                  seed = 32'hc590;
    int                  errors;
    int                  test_start;
    int                  failed_tests;
    logic                rd_check;    // Compare rdata on this read
    logic                count_check; // Count must not rise
    logic                irq_check;
    logic [15:0]         exp_rdata;
    logic [15:0]         last_count;
    logic [15:0]         rd_data;
    logic [num_leds-1:0] exp_leds;
    logic                exp_bios;
    logic                exp_intr;
    logic [2:0]          exp_irq_num;

    tb_clock_gen #(.period(100), .reset_cycles(4)) u_clock_gen (
        .sys_clk (sys_clk),
        .rst_n   (rst_n)
    );

    io_subsystem_top #(.num_leds(num_leds), .timer_prescale(timer_prescale)) dut_i (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .io_req       (io_req),
        .io_rsp       (io_rsp),
        .irq_in       (irq_in),
        .leds         (leds),
        .bios_enabled (bios_enabled),
        .intr         (intr),
        .irq_num      (irq_num)
    );

    a_reset_values: assert property (@(posedge sys_clk) $rose(rst_n) |->
        !io_rsp.ack && !intr && leds == '0 && bios_enabled)
        else begin
            $display("Fail at %0t: outputs are not at their reset values", $time);
            errors++;
        end

    a_ack_latency: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $rose(io_req.access) |-> !io_rsp.ack ##1 !io_rsp.ack ##1 io_rsp.ack ##1 !io_rsp.ack)
        else begin
            $display("Fail at %0t: ack was not one pulse two cycles after access", $time);
            errors++;
        end

    a_ack_in_access: assert property (@(posedge sys_clk) disable iff (!rst_n)
        io_rsp.ack |-> io_req.access)
        else begin
            $display("Fail at %0t: ack arrived without an access", $time);
            errors++;
        end

    a_rdata_idle: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !io_rsp.ack |-> io_rsp.rdata == '0)
        else begin
            $display("Fail at %0t: io_rsp.rdata expected 0000, got %h",
                     $time, $sampled(io_rsp.rdata));
            errors++;
        end

    a_read_data: assert property (@(posedge sys_clk) disable iff (!rst_n)
        io_rsp.ack && rd_check |-> io_rsp.rdata == exp_rdata)
        else begin
            $display("Fail at %0t: io_rsp.rdata expected %h, got %h",
                     $time, $sampled(exp_rdata), $sampled(io_rsp.rdata));
            errors++;
        end

    a_count_down: assert property (@(posedge sys_clk) disable iff (!rst_n)
        io_rsp.ack && count_check |-> io_rsp.rdata <= last_count)
        else begin
            $display("Fail at %0t: timer count expected at most %h, got %h",
                     $time, $sampled(last_count), $sampled(io_rsp.rdata));
            errors++;
        end

    a_leds: assert property (@(posedge sys_clk) disable iff (!rst_n)
        io_rsp.ack |-> leds == exp_leds)
        else begin
            $display("Fail at %0t: leds expected %h, got %h",
                     $time, $sampled(exp_leds), $sampled(leds));
            errors++;
        end

    a_bios: assert property (@(posedge sys_clk) disable iff (!rst_n)
        io_rsp.ack |-> bios_enabled == exp_bios)
        else begin
            $display("Fail at %0t: bios_enabled expected %b, got %b",
                     $time, $sampled(exp_bios), $sampled(bios_enabled));
            errors++;
        end

    a_intr: assert property (@(posedge sys_clk) disable iff (!rst_n)
        irq_check |-> intr == exp_intr)
        else begin
            $display("Fail at %0t: intr expected %b, got %b",
                     $time, $sampled(exp_intr), $sampled(intr));
            errors++;
        end

    a_irq_num: assert property (@(posedge sys_clk) disable iff (!rst_n)
        irq_check && exp_intr |-> irq_num == exp_irq_num)
        else begin
            $display("Fail at %0t: irq_num expected %0d, got %0d",
                     $time, $sampled(exp_irq_num), $sampled(irq_num));
            errors++;
        end

    // One host access, entered and left on a falling edge
    task automatic bus_access(input logic [15:0] addr, input logic wr,
                              input logic [1:0] bsel, input logic [15:0] wdata);
        int waited;
        waited         = 0;
        io_req.addr    = addr[15:1];
        io_req.wr_en   = wr;
        io_req.bytesel = bsel;
        io_req.wdata   = wdata;
        io_req.access  = 1'b1;
        @(negedge sys_clk);
        while (!io_rsp.ack && waited < 8) begin
            @(negedge sys_clk);
            waited++;
        end
        if (!io_rsp.ack) begin
            $display("No acknowledge for the access to address %h", addr);
            errors++;
        end
        rd_data = io_rsp.rdata;
        @(negedge sys_clk);
        io_req = '0;
        @(negedge sys_clk); // Idle cycle
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [1:0] bsel,
                             input logic [15:0] wdata);
        bus_access(addr, 1'b1, bsel, wdata);
    endtask

    task automatic read_reg(input logic [15:0] addr, input logic check,
                            input logic [15:0] expected);
        exp_rdata = expected;
        rd_check  = check;
        bus_access(addr, 1'b0, 2'b11, 16'h0);
        rd_check  = 1'b0;
    endtask

    task automatic wait_for_intr(input int max_cycles);
        int n;
        n = 0;
        while (!intr && n < max_cycles) begin
            @(negedge sys_clk);
            n++;
        end
        if (!intr) begin
            $display("Timer interrupt did not arrive within %0d cycles", max_cycles);
            errors++;
        end
    endtask

    task automatic expect_irq(input logic pending, input logic [2:0] line);
        exp_intr    = pending;
        exp_irq_num = line;
        irq_check   = 1'b1;
        @(negedge sys_clk);
        irq_check   = 1'b0;
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d failures", name, errors - test_start);
        if (errors != test_start)
            failed_tests++;
        test_start = errors;
    endtask

    function automatic logic is_mapped(input logic [15:0] addr);
        return addr == ADDR_LEDS || addr == ADDR_BIOS_CTRL || addr == ADDR_IRQ_TEST ||
               addr == ADDR_TIMER_COUNT || addr == ADDR_TIMER_CTRL || addr == ADDR_PIC;
    endfunction

    initial begin
        repeat (watchdog_cycles) @(posedge sys_clk);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [15:0] rnd;
        logic [15:0] wdata;
        logic [1:0]  bsel;
        logic [15:0] n;
        io_req       = '0;
        irq_in       = '0;
        rd_check     = 1'b0;
        count_check  = 1'b0;
        irq_check    = 1'b0;
        exp_rdata    = '0;
        last_count   = '0;
        rd_data      = '0;
        exp_leds     = '0;
        exp_bios     = 1'b1;
        exp_intr     = 1'b0;
        exp_irq_num  = '0;
        errors       = 0;
        test_start   = 0;
        failed_tests = 0;
        @(posedge rst_n);
        @(negedge sys_clk);

        // Every mapped address once
        read_reg(ADDR_LEDS, 1'b1, 16'h0);
        read_reg(ADDR_BIOS_CTRL, 1'b1, 16'h1);
        read_reg(ADDR_TIMER_COUNT, 1'b0, 16'h0);
        read_reg(ADDR_TIMER_CTRL, 1'b0, 16'h0);
        read_reg(ADDR_PIC, 1'b1, 16'h0);
        read_reg(ADDR_IRQ_TEST, 1'b0, 16'h0);
        write_reg(ADDR_TIMER_COUNT, 2'b11, 16'h0);
        end_test("Handshake");

        repeat (16) begin
            wdata = 16'($random(seed));
            bsel  = 2'($random(seed));
            for (int i = 0; i < num_leds; i++) begin
                if (bsel[i / 8])
                    exp_leds[i] = wdata[i];
            end
            write_reg(ADDR_LEDS, bsel, wdata);
            read_reg(ADDR_LEDS, 1'b1, 16'(exp_leds));
        end
        exp_bios = 1'b0;
        write_reg(ADDR_BIOS_CTRL, 2'b01, 16'h0000);
        read_reg(ADDR_BIOS_CTRL, 1'b1, 16'h0);
        write_reg(ADDR_BIOS_CTRL, 2'b10, 16'hffff); // High lane only
        read_reg(ADDR_BIOS_CTRL, 1'b1, 16'h0);
        exp_bios = 1'b1;
        write_reg(ADDR_BIOS_CTRL, 2'b01, 16'h0001);
        read_reg(ADDR_BIOS_CTRL, 1'b1, 16'h1);
        end_test("Registers");

        repeat (8) begin
            rnd = 16'($random(seed)) & 16'hfffe;
            while (is_mapped(rnd))
                rnd = 16'($random(seed)) & 16'hfffe;
            read_reg(rnd, 1'b1, 16'h0);
            write_reg(rnd, 2'b11, 16'hffff); // Must not touch any register
        end
        end_test("Unmapped address");

        n = 16'(3 + ($random(seed) & 7));
        write_reg(ADDR_TIMER_COUNT, 2'b11, n);
        write_reg(ADDR_TIMER_CTRL, 2'b01, 16'(TIMER_ONESHOT));
        last_count  = n;
        count_check = 1'b1;
        for (int k = 0; k < 64 && !intr; k++) begin
            read_reg(ADDR_TIMER_COUNT, 1'b0, 16'h0);
            last_count = rd_data;
        end
        count_check = 1'b0;
        wait_for_intr(timer_prescale * n + 8);
        read_reg(ADDR_PIC, 1'b1, 16'h0001);
        write_reg(ADDR_PIC, 2'b01, 16'h0001);
        repeat (timer_prescale * (n + 2)) @(negedge sys_clk);
        expect_irq(1'b0, 3'd0); // No second pulse in one-shot mode
        read_reg(ADDR_TIMER_CTRL, 1'b1, 16'(TIMER_STOPPED));
        read_reg(ADDR_TIMER_COUNT, 1'b1, 16'h0);
        write_reg(ADDR_TIMER_COUNT, 2'b11, n);
        write_reg(ADDR_TIMER_CTRL, 2'b01, 16'(TIMER_PERIODIC));
        wait_for_intr(timer_prescale * n + 8);
        write_reg(ADDR_PIC, 2'b01, 16'h0001);
        expect_irq(1'b0, 3'd0);
        wait_for_intr(timer_prescale * n + 8);
        write_reg(ADDR_TIMER_CTRL, 2'b01, 16'(TIMER_STOPPED));
        write_reg(ADDR_PIC, 2'b01, 16'h00ff);
        expect_irq(1'b0, 3'd0);
        end_test("Timer");

        // Test bit k drives line k+1
        write_reg(ADDR_IRQ_TEST, 2'b01, 16'((1 << (3 - 1)) | (1 << (5 - 1))));
        expect_irq(1'b1, 3'd3);
        read_reg(ADDR_IRQ_TEST, 1'b1, 16'h0014);
        read_reg(ADDR_PIC, 1'b1, 16'h0028);
        write_reg(ADDR_PIC, 2'b10, 16'h0800); // Mask line 3
        expect_irq(1'b1, 3'd5);
        write_reg(ADDR_PIC, 2'b11, 16'h0820); // EOI line 5, mask kept
        expect_irq(1'b0, 3'd0);
        irq_in = 7'b000_0010;                 // Line 2
        repeat (2) @(negedge sys_clk);
        expect_irq(1'b1, 3'd2);
        irq_in = '0;
        end_test("Interrupts");

        $display("Tests run: 5, tests failed: %0d, failed checks: %0d", failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
verilog/soc_io_pkg.sv
verilog/io_decoder.sv
verilog/system_control.sv
verilog/interval_timer.sv
verilog/irq_controller.sv
verilog/io_subsystem_top.sv
verification/tb_clock_gen.sv
verification/io_subsystem_tb.sv

/* Bender.yml */
package:
  name: io_subsystem

sources:
  # RTL, package first
  - files:
      - verilog/soc_io_pkg.sv
      - verilog/io_decoder.sv
      - verilog/system_control.sv
      - verilog/interval_timer.sv
      - verilog/irq_controller.sv
      - verilog/io_subsystem_top.sv

  # Testbench
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/io_subsystem_tb.sv
